// File: src/otter_pkg.sv
package otter_pkg;

    //////////////////////////////////////////////////
    // Widths and vectors
    //////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // First fetch address after reset
    localparam logic [XLEN-1:0] RESET_VEC = 32'h0000_0000;

    // Branch conditions by funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // ALU functions by funct3, shared by OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // Major opcodes of the kept instruction set
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    // ADD is zero so a cleared control word adds
    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_SLL      = 4'd2,
        ALU_SLT      = 4'd3,
        ALU_SLTU     = 4'd4,
        ALU_XOR      = 4'd5,
        ALU_SRL      = 4'd6,
        ALU_SRA      = 4'd7,
        ALU_OR       = 4'd8,
        ALU_AND      = 4'd9,
        ALU_LUI_COPY = 4'd10
    } alu_op_e;

    // Register write source
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_PC4  = 2'd1,
        WB_LOAD = 2'd2
    } wb_sel_e;

    // NOP is zero, an all-zero control word retires nothing
    typedef enum logic [2:0] {
        CLS_NOP    = 3'd0,
        CLS_ALU    = 3'd1,
        CLS_BRANCH = 3'd2,
        CLS_JAL    = 3'd3,
        CLS_JALR   = 3'd4,
        CLS_LOAD   = 3'd5,
        CLS_STORE  = 3'd6
    } op_class_e;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_EXEC  = 2'd1,
        ST_WR_BK = 2'd2
    } state_e;

    //////////////////////////////////////////////////
    // Bundles
    //////////////////////////////////////////////////

    // Decoded instruction
    typedef struct packed {
        op_class_e             op_class;
        alu_op_e               alu_op;
        logic                  src_a_pc;
        logic                  src_b_imm;
        wb_sel_e               wb_sel;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [2:0]            funct3;
        logic [XLEN-1:0]       imm;
    } ctrl_t;

    // Word-only data memory request
    typedef struct packed {
        logic            re;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] w_data;
    } dmem_req_t;

endpackage

// File: src/otter_decoder.sv
module otter_decoder (
    input  logic [otter_pkg::XLEN-1:0] i_instrn,
    input  logic                       i_active,
    output otter_pkg::ctrl_t           o_ctrl
);
    import otter_pkg::*;

    opcode_e         opc;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Map funct3 plus the funct7 alternate bit onto an ALU operation
    function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB : op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL     : op = ALU_SLL;
            F3_SLT     : op = ALU_SLT;
            F3_SLTU    : op = ALU_SLTU;
            F3_XOR     : op = ALU_XOR;
            F3_SRL_SRA : op = alt ? ALU_SRA : ALU_SRL;
            F3_OR      : op = ALU_OR;
            default    : op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opc = opcode_e'(i_instrn[6:0]);

    //////////////////////////////////////////////////
    // Immediate formats
    //////////////////////////////////////////////////

    assign imm_i = {{20{i_instrn[31]}}, i_instrn[31:20]};
    assign imm_s = {{20{i_instrn[31]}}, i_instrn[31:25], i_instrn[11:7]};
    // Branch and jump offsets are always even
    assign imm_b = {{20{i_instrn[31]}}, i_instrn[7], i_instrn[30:25], i_instrn[11:8], 1'b0};
    assign imm_u = {i_instrn[31:12], 12'h000};
    assign imm_j = {{12{i_instrn[31]}}, i_instrn[19:12], i_instrn[20], i_instrn[30:21], 1'b0};

    //////////////////////////////////////////////////
    // Control word
    //////////////////////////////////////////////////

    always_comb begin
        o_ctrl = '0;
        if (i_active) begin
            // Register fields sit at fixed positions in every format
            o_ctrl.rd     = i_instrn[11:7];
            o_ctrl.rs1    = i_instrn[19:15];
            o_ctrl.rs2    = i_instrn[24:20];
            o_ctrl.funct3 = i_instrn[14:12];
            case (opc)
                OPC_OP : begin
                    o_ctrl.op_class = CLS_ALU;
                    o_ctrl.alu_op   = alu_from_funct3(i_instrn[14:12], i_instrn[30]);
                    o_ctrl.reg_we   = 1'b1;
                end
                OPC_OP_IMM : begin
                    o_ctrl.op_class  = CLS_ALU;
                    // Bit 30 is immediate data except for SRAI
                    o_ctrl.alu_op    = alu_from_funct3(i_instrn[14:12],
                        i_instrn[30] && (i_instrn[14:12] == F3_SRL_SRA));
                    o_ctrl.src_b_imm = 1'b1;
                    o_ctrl.reg_we    = 1'b1;
                    o_ctrl.imm       = imm_i;
                end
                OPC_LUI : begin
                    o_ctrl.op_class  = CLS_ALU;
                    o_ctrl.alu_op    = ALU_LUI_COPY;
                    o_ctrl.src_b_imm = 1'b1;
                    o_ctrl.reg_we    = 1'b1;
                    o_ctrl.imm       = imm_u;
                end
                OPC_AUIPC : begin
                    o_ctrl.op_class  = CLS_ALU;
                    o_ctrl.src_a_pc  = 1'b1;
                    o_ctrl.src_b_imm = 1'b1;
                    o_ctrl.reg_we    = 1'b1;
                    o_ctrl.imm       = imm_u;
                end
                OPC_JAL : begin
                    o_ctrl.op_class = CLS_JAL;
                    o_ctrl.wb_sel   = WB_PC4;
                    o_ctrl.reg_we   = 1'b1;
                    o_ctrl.imm      = imm_j;
                end
                OPC_JALR : begin
                    o_ctrl.op_class = CLS_JALR;
                    o_ctrl.wb_sel   = WB_PC4;
                    o_ctrl.reg_we   = 1'b1;
                    o_ctrl.imm      = imm_i;
                end
                OPC_BRANCH : begin
                    o_ctrl.op_class = CLS_BRANCH;
                    o_ctrl.imm      = imm_b;
                end
                OPC_LOAD : begin
                    // Address is rs1 plus offset through the ALU
                    o_ctrl.op_class  = CLS_LOAD;
                    o_ctrl.src_b_imm = 1'b1;
                    o_ctrl.wb_sel    = WB_LOAD;
                    o_ctrl.reg_we    = 1'b1;
                    o_ctrl.imm       = imm_i;
                end
                OPC_STORE : begin
                    o_ctrl.op_class  = CLS_STORE;
                    o_ctrl.src_b_imm = 1'b1;
                    o_ctrl.imm       = imm_s;
                end
                // Unknown opcode retires as a no-op
                default : o_ctrl = '0;
            endcase
        end
    end

endmodule

// File: src/otter_regfile.sv
module otter_regfile (
    input  logic                             i_clk,
    input  logic                             i_we,
    input  logic [otter_pkg::REG_ADDR_W-1:0] i_rs1,
    input  logic [otter_pkg::REG_ADDR_W-1:0] i_rs2,
    input  logic [otter_pkg::REG_ADDR_W-1:0] i_rd,
    input  logic [otter_pkg::XLEN-1:0]       i_w_data,
    output logic [otter_pkg::XLEN-1:0]       o_rs1_data,
    output logic [otter_pkg::XLEN-1:0]       o_rs2_data
);
    import otter_pkg::*;

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    // Single write port, x0 is never written
    always_ff @(posedge i_clk) begin
        if (i_we && (i_rd != '0)) begin
            regs[i_rd] <= i_w_data;
        end
    end

    // Asynchronous reads, x0 reads as zero
    assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
    assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

// File: src/otter_alu.sv
module otter_alu (
    input  otter_pkg::ctrl_t           i_ctrl,
    input  logic [otter_pkg::XLEN-1:0] i_pc,
    input  logic [otter_pkg::XLEN-1:0] i_rs1_data,
    input  logic [otter_pkg::XLEN-1:0] i_rs2_data,
    output logic [otter_pkg::XLEN-1:0] o_result
);
    import otter_pkg::*;

    logic [XLEN-1:0] src_a;
    logic [XLEN-1:0] src_b;
    logic [4:0]      shamt;

    // Source A is PC only for AUIPC
    assign src_a = i_ctrl.src_a_pc ? i_pc : i_rs1_data;
    // Source B is the immediate for I, S and U formats
    assign src_b = i_ctrl.src_b_imm ? i_ctrl.imm : i_rs2_data;

    // Shift amount from the low five bits
    assign shamt = src_b[4:0];

    always_comb begin
        case (i_ctrl.alu_op)
            ALU_ADD      : o_result = src_a + src_b;
            ALU_SUB      : o_result = src_a - src_b;
            ALU_SLL      : o_result = src_a << shamt;
            ALU_SLT      : o_result = {{(XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_SLTU     : o_result = {{(XLEN-1){1'b0}}, src_a < src_b};
            ALU_XOR      : o_result = src_a ^ src_b;
            ALU_SRL      : o_result = src_a >> shamt;
            // Arithmetic shift keeps the sign
            ALU_SRA      : o_result = $signed(src_a) >>> shamt;
            ALU_OR       : o_result = src_a | src_b;
            ALU_AND      : o_result = src_a & src_b;
            // LUI passes the upper immediate through
            ALU_LUI_COPY : o_result = src_b;
            default      : o_result = '0;
        endcase
    end

endmodule

// File: src/otter_branch_unit.sv
module otter_branch_unit (
    input  otter_pkg::ctrl_t           i_ctrl,
    input  logic [otter_pkg::XLEN-1:0] i_pc,
    input  logic [otter_pkg::XLEN-1:0] i_rs1_data,
    input  logic [otter_pkg::XLEN-1:0] i_rs2_data,
    output logic                       o_redirect,
    output logic [otter_pkg::XLEN-1:0] o_target
);
    import otter_pkg::*;

    logic            taken;
    logic [XLEN-1:0] jalr_sum;

    // Branch condition from funct3
    always_comb begin
        case (i_ctrl.funct3)
            F3_BEQ  : taken = (i_rs1_data == i_rs2_data);
            F3_BNE  : taken = (i_rs1_data != i_rs2_data);
            F3_BLT  : taken = ($signed(i_rs1_data) < $signed(i_rs2_data));
            F3_BGE  : taken = ($signed(i_rs1_data) >= $signed(i_rs2_data));
            F3_BLTU : taken = (i_rs1_data < i_rs2_data);
            F3_BGEU : taken = (i_rs1_data >= i_rs2_data);
            // Reserved encodings never branch
            default : taken = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // Target and redirect
    //////////////////////////////////////////////////

    assign jalr_sum = i_rs1_data + i_ctrl.imm;

    // JALR clears bit zero, JAL and branches are PC relative
    assign o_target = (i_ctrl.op_class == CLS_JALR) ? {jalr_sum[XLEN-1:1], 1'b0}
                                                    : i_pc + i_ctrl.imm;

    assign o_redirect = (i_ctrl.op_class == CLS_JAL)
                     || (i_ctrl.op_class == CLS_JALR)
                     || ((i_ctrl.op_class == CLS_BRANCH) && taken);

endmodule

// File: src/otter_fetch_ctrl.sv
module otter_fetch_ctrl (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic [otter_pkg::XLEN-1:0] i_imem_r_data,
    input  logic                       i_is_load,
    input  logic                       i_redirect,
    input  logic [otter_pkg::XLEN-1:0] i_target,
    output logic [otter_pkg::XLEN-1:0] o_pc,
    output logic [otter_pkg::XLEN-1:0] o_imem_addr,
    output logic [otter_pkg::XLEN-1:0] o_instrn,
    output otter_pkg::state_e          o_state
);
    import otter_pkg::*;

    state_e          state_q;
    state_e          state_d;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic            stall;
    logic            stall_q;
    logic [XLEN-1:0] instrn_q;

    //////////////////////////////////////////////////
    // State machine
    //////////////////////////////////////////////////

    // Load in EXEC holds the PC for one write-back cycle
    assign stall = (state_q == ST_EXEC) && i_is_load;

    always_comb begin
        case (state_q)
            ST_INIT  : state_d = ST_EXEC;
            ST_EXEC  : state_d = i_is_load ? ST_WR_BK : ST_EXEC;
            ST_WR_BK : state_d = ST_EXEC;
            default  : state_d = ST_INIT;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state_q <= ST_INIT;
        end else begin
            state_q <= state_d;
        end
    end

    //////////////////////////////////////////////////
    // Program counter
    //////////////////////////////////////////////////

    always_comb begin
        case (state_q)
            // Jump or taken branch overrides the increment
            ST_EXEC  : pc_next = i_redirect ? i_target : pc_q + XLEN'(4);
            ST_WR_BK : pc_next = pc_q + XLEN'(4);
            default  : pc_next = RESET_VEC;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc_q <= RESET_VEC;
        end else if (!stall) begin
            pc_q <= pc_next;
        end
    end

    // Fetch ahead unless stalled, then refetch the current PC
    assign o_imem_addr = stall ? pc_q : pc_next;

    //////////////////////////////////////////////////
    // Held instruction
    //////////////////////////////////////////////////

    // Memory returns the next word during WR_BK, so replay the load
    always_ff @(posedge i_clk) begin
        instrn_q <= o_instrn;
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall;
        end
    end

    assign o_instrn = stall_q ? instrn_q : i_imem_r_data;
    assign o_pc     = pc_q;
    assign o_state  = state_q;

endmodule

// File: src/otter_mcu.sv
module otter_mcu (
    input  logic                       i_clk,
    input  logic                       i_rst,
    output logic [otter_pkg::XLEN-1:0] o_imem_addr,
    input  logic [otter_pkg::XLEN-1:0] i_imem_r_data,
    output otter_pkg::dmem_req_t       o_dmem_req,
    input  logic [otter_pkg::XLEN-1:0] i_dmem_r_data
);
    import otter_pkg::*;

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instrn;
    state_e          state;
    ctrl_t           ctrl;
    logic            active;
    logic            is_load;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] alu_result;
    logic            redirect;
    logic [XLEN-1:0] target;
    logic            rf_we;
    logic [XLEN-1:0] rf_w_data;

    //////////////////////////////////////////////////
    // Fetch and control
    //////////////////////////////////////////////////

    assign is_load = (ctrl.op_class == CLS_LOAD);

    otter_fetch_ctrl u_fetch_ctrl (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_imem_r_data (i_imem_r_data),
        .i_is_load     (is_load),
        .i_redirect    (redirect),
        .i_target      (target),
        .o_pc          (pc),
        .o_imem_addr   (o_imem_addr),
        .o_instrn      (instrn),
        .o_state       (state)
    );

    // Decode only while an instruction is executing
    assign active = (state == ST_EXEC) || (state == ST_WR_BK);

    otter_decoder u_decoder (
        .i_instrn (instrn),
        .i_active (active),
        .o_ctrl   (ctrl)
    );

    //////////////////////////////////////////////////
    // Register file and write-back
    //////////////////////////////////////////////////

    always_comb begin
        case (ctrl.wb_sel)
            WB_PC4  : rf_w_data = pc + XLEN'(4);
            WB_LOAD : rf_w_data = i_dmem_r_data;
            default : rf_w_data = alu_result;
        endcase
    end

    // Loads write in WR_BK, everything else in EXEC
    assign rf_we = ctrl.reg_we
                && (((state == ST_EXEC) && !is_load) || (state == ST_WR_BK));

    otter_regfile u_regfile (
        .i_clk      (i_clk),
        .i_we       (rf_we),
        .i_rs1      (ctrl.rs1),
        .i_rs2      (ctrl.rs2),
        .i_rd       (ctrl.rd),
        .i_w_data   (rf_w_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data)
    );

    //////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////

    otter_alu u_alu (
        .i_ctrl     (ctrl),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_result   (alu_result)
    );

    otter_branch_unit u_branch_unit (
        .i_ctrl     (ctrl),
        .i_pc       (pc),
        .i_rs1_data (rs1_data),
        .i_rs2_data (rs2_data),
        .o_redirect (redirect),
        .o_target   (target)
    );

    // Data memory request, strobes only in EXEC
    assign o_dmem_req.re     = (state == ST_EXEC) && is_load;
    assign o_dmem_req.we     = (state == ST_EXEC) && (ctrl.op_class == CLS_STORE);
    assign o_dmem_req.addr   = alu_result;
    assign o_dmem_req.w_data = rs2_data;

endmodule

// File: tb/otter_mcu_assertions.sv
module otter_mcu_assertions (
    input logic                       i_clk,
    input logic                       i_rst,
    input logic [otter_pkg::XLEN-1:0] o_imem_addr,
    input otter_pkg::dmem_req_t       o_dmem_req
);
    import otter_pkg::*;

    // Word-only memory never reads and writes at once
    a_strobes_exclusive : assert property (@(posedge i_clk) disable iff (!i_rst)
        !(o_dmem_req.re && o_dmem_req.we))
        else $error("dmem read and write strobes high together");

    // Fetches are always on word boundaries
    a_fetch_aligned : assert property (@(posedge i_clk) disable iff (!i_rst)
        o_imem_addr[1:0] == 2'b00)
        else $error("o_imem_addr not word aligned");

    a_reset_quiet : assert property (@(posedge i_clk) !i_rst |-> !o_dmem_req.re && !o_dmem_req.we)
        else $error("dmem strobe high during reset");

endmodule

bind otter_mcu otter_mcu_assertions u_assertions (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .o_imem_addr (o_imem_addr),
    .o_dmem_req  (o_dmem_req)
);

// File: tb/otter_mcu_tb.sv
module otter_mcu_tb;
    import otter_pkg::*;

    localparam logic [31:0] SEED       = 32'h203847cd;
    localparam int          N_RETIRE   = 3000;
    localparam int          MAX_CYCLE  = 8000;
    localparam int          HOLD_LIMIT = 8;

    logic            i_clk;
    logic            i_rst;
    logic [XLEN-1:0] o_imem_addr;
    logic [XLEN-1:0] i_imem_r_data = '0;
    dmem_req_t       o_dmem_req;
    logic [XLEN-1:0] i_dmem_r_data = '0;

    // Testbench memories and the request seen in the last cycle
    logic [31:0] imem [256];
    logic [31:0] dmem [64];
    logic [31:0] imem_addr_q = '0;
    dmem_req_t   dreq_q      = '0;
    int          dut_stores  = 0;

    // Reference model state
    logic [31:0] model_x   [32];
    logic [31:0] model_mem [64];
    logic [31:0] model_pc;
    int          model_stores = 0;
    int          errors       = 0;
    int          timeouts     = 0;

    otter_mcu DUT (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .o_imem_addr   (o_imem_addr),
        .i_imem_r_data (i_imem_r_data),
        .o_dmem_req    (o_dmem_req),
        .i_dmem_r_data (i_dmem_r_data)
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    //////////////////////////////////////////////////
    // Synchronous memories
    //////////////////////////////////////////////////

    // Requests latched mid-cycle and answered at the next rising edge
    always @(negedge i_clk) begin
        imem_addr_q <= o_imem_addr;
        dreq_q      <= o_dmem_req;
        if (i_rst && o_dmem_req.we) begin
            dut_stores <= dut_stores + 1;
        end
    end

    always @(posedge i_clk) begin
        i_imem_r_data <= imem[imem_addr_q[9:2]];
        i_dmem_r_data <= dmem[dreq_q.addr[7:2]];
        if (dreq_q.we) begin
            dmem[dreq_q.addr[7:2]] <= dreq_q.w_data;
        end
    end

    //////////////////////////////////////////////////
    // Checks and encoders
    //////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] act, input logic [31:0] exp);
        if (act !== exp) begin
            errors++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, act, exp);
        end
    endtask

    // Seed pattern built from every address bit
    function automatic logic [31:0] fill_word(input int idx);
        return (idx * 32'h045d_9f3b) ^ 32'hc3a5_0000 ^ (idx << 20) ^ idx;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
        return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    // Small nonzero word offset backward or forward
    function automatic int small_offset();
        int k;
        k = int'($urandom_range(0, 9)) - 3;
        if (k == 0) begin
            k = 2;
        end
        return k * 4;
    endfunction

    // One random legal instruction using only x0..x7
    function automatic logic [31:0] gen_instr();
        int          kind;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  bf3 [6];
        bf3  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        kind = $urandom_range(0, 99);
        f3   = 3'($urandom_range(0, 7));
        rd   = 5'($urandom_range(0, 7));
        rs1  = 5'($urandom_range(0, 7));
        rs2  = 5'($urandom_range(0, 7));
        if (kind < 25) begin
            if (f3 == 3'd1) begin
                return enc_i({7'h00, 5'($urandom)}, rs1, f3, rd, 7'b0010011);
            end else if (f3 == 3'd5) begin
                return enc_i({$urandom_range(0, 1) ? 7'h20 : 7'h00, 5'($urandom)},
                             rs1, f3, rd, 7'b0010011);
            end
            return enc_i(12'($urandom), rs1, f3, rd, 7'b0010011);
        end else if (kind < 45) begin
            return enc_r(((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(0, 1)) ? 7'h20 : 7'h00,
                         rs2, rs1, f3, rd);
        end else if (kind < 50) begin
            return {20'($urandom), rd, 7'b0110111};
        end else if (kind < 55) begin
            return {20'($urandom), rd, 7'b0010111};
        end else if (kind < 70) begin
            return enc_b(13'(small_offset()), rs2, rs1, bf3[$urandom_range(0, 5)]);
        end else if (kind < 74) begin
            return enc_j(21'(small_offset()), rd);
        end else if (kind < 78) begin
            // Odd immediate exercises the cleared bit zero
            return enc_i(12'(4 * $urandom_range(0, 255) + $urandom_range(0, 1)),
                         5'd0, 3'd0, rd, 7'b1100111);
        end else if (kind < 88) begin
            return enc_i(12'(4 * $urandom_range(0, 63)), 5'd0, 3'b010, rd, 7'b0000011);
        end
        return enc_s(12'(4 * $urandom_range(0, 63)), rs2);
    endfunction

    //////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0    : return alt ? a - b : a + b;
            3'd1    : return a << b[4:0];
            3'd2    : return {31'd0, $signed(a) < $signed(b)};
            3'd3    : return {31'd0, a < b};
            3'd4    : return a ^ b;
            3'd5    : return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6    : return a | b;
            default : return a & b;
        endcase
    endfunction

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] val);
        if (rd != 5'd0) begin
            model_x[rd] = val;
        end
    endtask

    // Executes the instruction at model_pc and reports next PC and memory traffic
    task automatic model_step(output logic [31:0] npc, output logic ld, output logic st,
                              output logic [31:0] addr, output logic [31:0] wdata);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] tgt;
        logic        take;
        ins   = imem[model_pc[9:2]];
        a     = model_x[ins[19:15]];
        b     = model_x[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        npc   = model_pc + 32'd4;
        ld    = 1'b0;
        st    = 1'b0;
        addr  = '0;
        wdata = '0;
        case (ins[6:0])
            7'b0110111 : write_reg(ins[11:7], {ins[31:12], 12'h000});
            7'b0010111 : write_reg(ins[11:7], model_pc + {ins[31:12], 12'h000});
            7'b0010011 : write_reg(ins[11:7],
                alu_ref(ins[14:12], ins[30] && ins[14:12] == 3'd5, a, imm_i));
            7'b0110011 : write_reg(ins[11:7], alu_ref(ins[14:12], ins[30], a, b));
            7'b1101111 : begin
                write_reg(ins[11:7], model_pc + 32'd4);
                npc = model_pc + imm_j;
            end
            7'b1100111 : begin
                tgt = (a + imm_i) & ~32'd1;
                write_reg(ins[11:7], model_pc + 32'd4);
                npc = tgt;
            end
            7'b1100011 : begin
                case (ins[14:12])
                    3'd0    : take = (a == b);
                    3'd1    : take = (a != b);
                    3'd4    : take = ($signed(a) < $signed(b));
                    3'd5    : take = ($signed(a) >= $signed(b));
                    3'd6    : take = (a < b);
                    3'd7    : take = (a >= b);
                    default : take = 1'b0;
                endcase
                if (take) begin
                    npc = model_pc + imm_b;
                end
            end
            7'b0000011 : begin
                ld   = 1'b1;
                addr = a + imm_i;
                write_reg(ins[11:7], model_mem[addr[7:2]]);
            end
            7'b0100011 : begin
                st    = 1'b1;
                addr  = a + imm_s;
                wdata = b;
                model_mem[addr[7:2]] = b;
                model_stores++;
            end
            default : ;
        endcase
    endtask

    //////////////////////////////////////////////////
    // Stimulus and comparison
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] npc;
        logic        ld;
        logic        st;
        logic [31:0] addr;
        logic [31:0] wdata;
        int          retired;
        int          cycles;
        int          hold;
        i_rst = 1'b0;
        void'($urandom(SEED));
        // Prologue gives x1..x7 defined values
        for (int i = 0; i < 256; i++) begin
            imem[i] = (i < 7) ? enc_i(12'($urandom), 5'd0, 3'd0, 5'(i + 1), 7'b0010011)
                              : gen_instr();
        end
        for (int i = 0; i < 64; i++) begin
            dmem[i]      = fill_word(i);
            model_mem[i] = fill_word(i);
        end
        for (int i = 0; i < 32; i++) begin
            model_x[i] = '0;
        end
        model_pc = RESET_VEC;

        // Core stays quiet through four reset cycles
        for (int c = 0; c < 4; c++) begin
            @(negedge i_clk);
            check_val("o_imem_addr", o_imem_addr, RESET_VEC);
            check_val("o_dmem_req.re", 32'(o_dmem_req.re), 32'd0);
            check_val("o_dmem_req.we", 32'(o_dmem_req.we), 32'd0);
        end
        i_rst = 1'b1;

        retired = 0;
        cycles  = 0;
        while (retired < N_RETIRE && cycles < MAX_CYCLE) begin
            @(negedge i_clk);
            cycles++;
            model_step(npc, ld, st, addr, wdata);
            check_val("o_dmem_req.re", 32'(o_dmem_req.re), 32'(ld));
            check_val("o_dmem_req.we", 32'(o_dmem_req.we), 32'(st));
            if (ld || st) begin
                check_val("o_dmem_req.addr", o_dmem_req.addr, addr);
            end
            if (st) begin
                check_val("o_dmem_req.w_data", o_dmem_req.w_data, wdata);
            end
            if (ld) begin
                // Fetch holds the load's PC until write-back ends
                check_val("o_imem_addr", o_imem_addr, model_pc);
                hold = 0;
                while (o_imem_addr == model_pc && hold < HOLD_LIMIT) begin
                    @(negedge i_clk);
                    cycles++;
                    hold++;
                    check_val("o_dmem_req.re", 32'(o_dmem_req.re), 32'd0);
                    check_val("o_dmem_req.we", 32'(o_dmem_req.we), 32'd0);
                end
                if (hold == HOLD_LIMIT) begin
                    timeouts++;
                    $display("Timeout: fetch address stuck at %h after a load", model_pc);
                    break;
                end
                check_val("load stall cycles", 32'(hold), 32'd1);
            end
            check_val("o_imem_addr", o_imem_addr, npc);
            model_pc = npc;
            retired++;
        end
        if (timeouts == 0 && retired < N_RETIRE) begin
            timeouts++;
            $display("Timeout: only %0d instructions retired in %0d cycles", retired, cycles);
        end
        @(negedge i_clk);
        check_val("store count", 32'(dut_stores), 32'(model_stores));

        $display("Done: %0d retired, %0d errors, %0d timeouts", retired, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
src/otter_pkg.sv
src/otter_decoder.sv
src/otter_regfile.sv
src/otter_alu.sv
src/otter_branch_unit.sv
src/otter_fetch_ctrl.sv
src/otter_mcu.sv
tb/otter_mcu_assertions.sv
tb/otter_mcu_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= otter_mcu_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
